// File: vlog.f
+incdir+hw
hw/soc_glue_pkg.sv
hw/addr_decoder.sv
hw/debug_req_holdoff.sv
hw/trace_select.sv
hw/soc_glue_top.sv
test/soc_glue_asserts.sv
test/soc_glue_tb.sv

// File: Bender.yml
package:
  name: soc_glue

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_glue_pkg.sv
      - hw/addr_decoder.sv
      - hw/debug_req_holdoff.sv
      - hw/trace_select.sv
      - hw/soc_glue_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/soc_glue_asserts.sv
      - test/soc_glue_tb.sv

// File: test/soc_glue_tb.sv
`include "soc_glue_params.svh"

`default_nettype none

module soc_glue_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import soc_glue_pkg::*;

  // Decode vector with its expected lookup result
  typedef struct packed {
    logic [`SOC_ADDR_WIDTH-1:0] addr;
    logic                       hit;
    periph_idx_e                idx;
  } dec_vec_t;

  // Two-core trace input and core select
  typedef struct packed {
    core_trace_t c0;
    core_trace_t c1;
    logic        sel;
  } trace_vec_t;

  localparam int DecTblLen   = 28;
  localparam int TraceTblLen = 4;
  localparam int RandCount   = 64;
  localparam int DbgTblLen   = 5;

  // --------------------------------------------------
  // Stimulus tables
  // --------------------------------------------------

  localparam dec_vec_t DEC_TBL [DecTblLen] = '{
    '{64'h0000_0000, 1'b1, DEBUG},
    '{64'h0000_0FFF, 1'b1, DEBUG},
    '{64'h0000_1000, 1'b0, DEBUG},
    '{64'h0001_0000, 1'b1, ROM},
    '{64'h0001_FFFF, 1'b1, ROM},
    '{64'h0002_0000, 1'b0, DEBUG},
    '{64'h0200_0000, 1'b1, CLINT},
    '{64'h020B_FFFF, 1'b1, CLINT},
    '{64'h020C_0000, 1'b0, DEBUG},
    '{64'h0C00_0000, 1'b1, PLIC},
    '{64'h0FFF_FFFF, 1'b1, PLIC},
    '{64'h1000_0000, 1'b0, DEBUG},
    '{64'h1A10_0000, 1'b1, APB},
    '{64'h1A1F_FFFF, 1'b1, APB},
    '{64'h1A20_0000, 1'b0, DEBUG},
    '{64'h1C00_0000, 1'b1, L2SPM},
    '{64'h1C07_FFFF, 1'b1, L2SPM},
    '{64'h1C08_0000, 1'b0, DEBUG},
    '{64'h8000_0000, 1'b1, HYPER},
    '{64'hBFFF_FFFF, 1'b1, HYPER},
    '{64'hC000_0000, 1'b0, DEBUG},
    '{64'h7000_0000, 1'b1, HYPER},
    '{64'h7001_FFFF, 1'b1, HYPER},
    '{64'h7002_0000, 1'b0, DEBUG},
    '{64'h0000_8000, 1'b0, DEBUG},
    '{64'h6FFF_FFFF, 1'b0, DEBUG},
    '{64'h1_0000_0000, 1'b0, DEBUG},
    '{64'hFFFF_FFFF_FFFF_FFFF, 1'b0, DEBUG}
  };

  localparam logic [`SOC_NUM_HARTS-1:0] DBG_TBL [DbgTblLen] = '{
    2'b00, 2'b01, 2'b10, 2'b11, 2'b01
  };

  logic                                     clk_i;
  logic                                     ndmreset_n;
  logic                                     dec_req_i;
  logic [`SOC_ADDR_WIDTH-1:0]               dec_addr_i;
  logic                                     dec_valid_o;
  logic                                     dec_hit_o;
  periph_idx_e                              dec_idx_o;
  logic [`SOC_NUM_HARTS-1:0]                dbg_req_i;
  logic [`SOC_NUM_HARTS-1:0]                dbg_req_o;
  logic                                     dbg_holdoff_o;
  core_trace_t [`SOC_NUM_HARTS-1:0]         core_trace_i;
  logic                                     core_sel_i;
  snoop_trace_t                             trace_o;

  int          checks;
  int          errors;
  logic [31:0] lcg_state;
  trace_vec_t  trace_tbl [TraceTblLen];

  soc_glue_top dut0 (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .dec_req_i     ( dec_req_i     ),
    .dec_addr_i    ( dec_addr_i    ),
    .dec_valid_o   ( dec_valid_o   ),
    .dec_hit_o     ( dec_hit_o     ),
    .dec_idx_o     ( dec_idx_o     ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_req_o     ( dbg_req_o     ),
    .dbg_holdoff_o ( dbg_holdoff_o ),
    .core_trace_i  ( core_trace_i  ),
    .core_sel_i    ( core_sel_i    ),
    .trace_o       ( trace_o       )
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic compare_value(input string test, input string what,
                               input logic [255:0] exp, input logic [255:0] act);
    checks++;
    assert (act === exp)
      else begin
        $display("FAIL %s %s: expected %0h, actual %0h", test, what, exp, act);
        errors++;
      end
  endtask

  task automatic report_test(input string test, input int chk0, input int err0);
    $display("test %s: %0d checks, %0d errors", test, checks - chk0, errors - err0);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Mix of near-rule, low-range and fully random addresses
  function automatic logic [`SOC_ADDR_WIDTH-1:0] random_address();
    logic [31:0] r;
    logic [31:0] off;
    r   = next_rand();
    off = next_rand();
    case (r[1:0])
      2'd0:    return {next_rand(), off};
      2'd1:    return {32'h0, off};
      default: return ADDR_MAP[r[4:2]].start_addr + {46'b0, off[17:0]} - 64'h800;
    endcase
  endfunction

  // First rule in table order that covers the address
  function automatic dec_vec_t expected_decode(input logic [`SOC_ADDR_WIDTH-1:0] addr);
    dec_vec_t v;
    v.addr = addr;
    v.hit  = 1'b0;
    v.idx  = DEBUG;
    for (int i = 0; i < `SOC_NUM_RULES; i++) begin
      if (!v.hit && addr >= ADDR_MAP[i].start_addr && addr < ADDR_MAP[i].end_addr) begin
        v.hit = 1'b1;
        v.idx = ADDR_MAP[i].idx;
      end
    end
    return v;
  endfunction

  function automatic core_trace_t make_trace(input logic v,
      input logic [`SOC_PC_WIDTH-1:0] src, input logic [`SOC_PC_WIDTH-1:0] dst,
      input logic [3:0] meta, input priv_lvl_e priv, input logic [31:0] op);
    core_trace_t t;
    t.pc_src_v = v;
    t.pc_src   = src;
    t.pc_dst   = dst;
    t.metadata = meta;
    t.priv     = priv;
    t.opcode   = op;
    return t;
  endfunction

  // High word is the PC shifted down, low word the PC with bit 0 cleared
  function automatic snoop_trace_t expected_trace(input core_trace_t t);
    snoop_trace_t f;
    f.priv_lvl = t.priv;
    f.pc_src_h = 32'(t.pc_src >> 32);
    f.pc_src_l = 32'(t.pc_src) & 32'hFFFF_FFFE;
    f.pc_dst_h = 32'(t.pc_dst >> 32);
    f.pc_dst_l = 32'(t.pc_dst) & 32'hFFFF_FFFE;
    f.metadata = 32'(t.metadata);
    f.opcode   = t.opcode;
    f.pc_v     = t.pc_src_v;
    return f;
  endfunction

  task automatic fill_trace_table();
    trace_tbl[0].c0  = make_trace(1'b1, 63'h0000_0000_8000_0004, 63'h0000_0000_8000_0100,
                                  4'h3, PRIV_LVL_M, 32'h0000_006F);
    trace_tbl[0].c1  = make_trace(1'b0, 63'h0, 63'h0, 4'h0, PRIV_LVL_U, 32'h0);
    trace_tbl[0].sel = 1'b0;
    trace_tbl[1].c0  = trace_tbl[0].c0;
    trace_tbl[1].c1  = make_trace(1'b1, 63'h7FFF_FFFF_FFFF_FFFE, 63'h4000_0000_0000_0002,
                                  4'hF, PRIV_LVL_S, 32'hFFFF_FFFF);
    trace_tbl[1].sel = 1'b1;
    trace_tbl[2].c0  = make_trace(1'b1, 63'h5555_5555_5555_5555, 63'h2AAA_AAAA_AAAA_AAAA,
                                  4'hA, PRIV_LVL_U, 32'h0000_0013);
    trace_tbl[2].c1  = trace_tbl[1].c1;
    trace_tbl[2].sel = 1'b0;
    trace_tbl[3].c0  = trace_tbl[2].c0;
    trace_tbl[3].c1  = make_trace(1'b1, 63'h0000_0001_0000_0000, 63'h0000_0000_FFFF_FFFE,
                                  4'h5, PRIV_LVL_M, 32'h1050_0073);
    trace_tbl[3].sel = 1'b1;
  endtask

  task automatic check_reset_values(input string test);
    compare_value(test, "dec_valid_o", '0, dec_valid_o);
    compare_value(test, "dbg_req_o", '0, dbg_req_o);
    compare_value(test, "dbg_holdoff_o", 1, dbg_holdoff_o);
    compare_value(test, "trace_o", '0, trace_o);
  endtask

  // Back-to-back requests, each result checked one cycle later
  task automatic apply_decode(input string test, input dec_vec_t vecs[$]);
    int n;
    n = vecs.size();
    for (int i = 0; i <= n; i++) begin
      @(posedge clk_i);
      if (i < n) begin
        dec_req_i  <= 1'b1;
        dec_addr_i <= vecs[i].addr;
      end else begin
        dec_req_i  <= 1'b0;
      end
      @(negedge clk_i);
      if (i > 0) begin
        compare_value(test, "dec_valid_o", 1, dec_valid_o);
        compare_value(test, $sformatf("hit @%0h", vecs[i-1].addr), vecs[i-1].hit, dec_hit_o);
        compare_value(test, $sformatf("idx @%0h", vecs[i-1].addr), vecs[i-1].idx, dec_idx_o);
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    compare_value(test, "dec_valid_o idle", '0, dec_valid_o);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : p_main
    dec_vec_t    vecs[$];
    trace_vec_t  tv;
    int          chk0;
    int          err0;
    int          cycle;
    int          asrt_fails;

    clk_i        = 1'b0;
    ndmreset_n   = 1'b0;
    // Strobe and traces active in reset, so only the reset holds the outputs low
    dec_req_i    = 1'b1;
    dec_addr_i   = '0;
    dbg_req_i    = '1;
    core_trace_i = '1;
    core_sel_i   = 1'b0;
    checks       = 0;
    errors       = 0;
    lcg_state    = 32'h67f76616;
    fill_trace_table();

    // Reset held for 16 edges, last check lands right after release
    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk_i);
      if (i == 14) begin
        dec_req_i <= 1'b0;
      end
      if (i == 15) begin
        ndmreset_n <= 1'b1;
      end
      @(negedge clk_i);
      check_reset_values("reset_values");
    end
    report_test("reset_values", chk0, err0);

    // Cycle k is the k-th rising edge after release
    chk0  = checks;
    err0  = errors;
    cycle = 0;
    while (dbg_holdoff_o && cycle < `SOC_DMI_DEL_CYCLES + 20) begin
      @(posedge clk_i);
      @(negedge clk_i);
      cycle++;
      if (cycle < `SOC_DMI_DEL_CYCLES) begin
        compare_value("holdoff", $sformatf("dbg_req_o cycle %0d", cycle), '0, dbg_req_o);
      end
    end
    if (dbg_holdoff_o) begin
      $display("Timeout: debug hold-off still active after %0d cycles", cycle);
      errors++;
    end else begin
      compare_value("holdoff", "release cycle", `SOC_DMI_DEL_CYCLES, cycle);
      compare_value("holdoff", "dbg_req_o at release", dbg_req_i, dbg_req_o);
    end
    for (int i = 0; i < DbgTblLen; i++) begin
      @(posedge clk_i);
      dbg_req_i <= DBG_TBL[i];
      @(negedge clk_i);
      compare_value("holdoff", $sformatf("dbg_req_o entry %0d", i), DBG_TBL[i], dbg_req_o);
    end
    report_test("holdoff", chk0, err0);

    chk0 = checks;
    err0 = errors;
    vecs.delete();
    for (int i = 0; i < DecTblLen; i++) begin
      vecs.push_back(DEC_TBL[i]);
    end
    apply_decode("decode_table", vecs);
    report_test("decode_table", chk0, err0);

    chk0 = checks;
    err0 = errors;
    vecs.delete();
    for (int i = 0; i < RandCount; i++) begin
      vecs.push_back(expected_decode(random_address()));
    end
    apply_decode("decode_random", vecs);
    report_test("decode_random", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i <= TraceTblLen; i++) begin
      @(posedge clk_i);
      if (i < TraceTblLen) begin
        core_trace_i[0] <= trace_tbl[i].c0;
        core_trace_i[1] <= trace_tbl[i].c1;
        core_sel_i      <= trace_tbl[i].sel;
      end
      @(negedge clk_i);
      if (i > 0) begin
        tv = trace_tbl[i-1];
        compare_value("trace_select", $sformatf("trace_o entry %0d", i - 1),
                      expected_trace(tv.sel ? tv.c1 : tv.c0), trace_o);
      end
    end
    report_test("trace_select", chk0, err0);

    asrt_fails = dut0.i_soc_glue_asserts.fail_count;
    $display("Total: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/soc_glue_asserts.sv
`include "soc_glue_params.svh"

`default_nettype none

module soc_glue_asserts (
  input logic                      clk_i,
  input logic                      ndmreset_n,
  input logic                      dec_req_i,
  input logic                      dec_valid_o,
  input logic [`SOC_NUM_HARTS-1:0] dbg_req_o,
  input logic                      dbg_holdoff_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // --------------------------------------------------
  // Address decode strobe
  // --------------------------------------------------

  a_dec_valid_reset: assert property (@(posedge clk_i) !ndmreset_n |-> !dec_valid_o)
    else begin
      $error("dec_valid_o high during reset");
      fail_count++;
    end

  // Result strobe lags the request by one cycle
  a_dec_valid_follows: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
                                        dec_valid_o == $past(dec_req_i))
    else begin
      $error("dec_valid_o does not follow the previous dec_req_i");
      fail_count++;
    end

  // --------------------------------------------------
  // Debug hold-off
  // --------------------------------------------------

  a_dbg_gated: assert property (@(posedge clk_i) dbg_holdoff_o |-> dbg_req_o == '0)
    else begin
      $error("dbg_req_o not gated during hold-off");
      fail_count++;
    end

  a_holdoff_stays_low: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
                                        !dbg_holdoff_o |=> !dbg_holdoff_o)
    else begin
      $error("dbg_holdoff_o rose again after release");
      fail_count++;
    end

endmodule

bind soc_glue_top soc_glue_asserts i_soc_glue_asserts (
  .clk_i         ( clk_i         ),
  .ndmreset_n    ( ndmreset_n    ),
  .dec_req_i     ( dec_req_i     ),
  .dec_valid_o   ( dec_valid_o   ),
  .dbg_req_o     ( dbg_req_o     ),
  .dbg_holdoff_o ( dbg_holdoff_o )
);

`default_nettype wire

// File: hw/soc_glue_top.sv
`include "soc_glue_params.svh"

`default_nettype none

module soc_glue_top #(
  parameter int unsigned DelCycles = `SOC_DMI_DEL_CYCLES
) (
  input  logic                                           clk_i,
  input  logic                                           ndmreset_n,
  // Crossbar address decode
  input  logic                                           dec_req_i,
  input  logic [`SOC_ADDR_WIDTH-1:0]                     dec_addr_i,
  output logic                                           dec_valid_o,
  output logic                                           dec_hit_o,
  output soc_glue_pkg::periph_idx_e                      dec_idx_o,
  // Hart debug requests
  input  logic [`SOC_NUM_HARTS-1:0]                      dbg_req_i,
  output logic [`SOC_NUM_HARTS-1:0]                      dbg_req_o,
  output logic                                           dbg_holdoff_o,
  // Control-flow traces
  input  soc_glue_pkg::core_trace_t [`SOC_NUM_HARTS-1:0] core_trace_i,
  input  logic                                           core_sel_i,
  output soc_glue_pkg::snoop_trace_t                     trace_o
);

  // --------------------------------------------------
  // Address map lookup
  // --------------------------------------------------

  addr_decoder i_addr_decoder (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .dec_req_i   ( dec_req_i   ),
    .dec_addr_i  ( dec_addr_i  ),
    .dec_valid_o ( dec_valid_o ),
    .dec_hit_o   ( dec_hit_o   ),
    .dec_idx_o   ( dec_idx_o   )
  );

  // --------------------------------------------------
  // Debug request gating
  // --------------------------------------------------

  debug_req_holdoff #(
    .DelCycles ( DelCycles )
  ) i_debug_req_holdoff (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_req_o     ( dbg_req_o     ),
    .dbg_holdoff_o ( dbg_holdoff_o )
  );

  // --------------------------------------------------
  // Trace selection for the snooper
  // --------------------------------------------------

  trace_select i_trace_select (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .core_trace_i ( core_trace_i ),
    .core_sel_i   ( core_sel_i   ),
    .trace_o      ( trace_o      )
  );

endmodule

`default_nettype wire

// File: hw/trace_select.sv
`include "soc_glue_params.svh"

`default_nettype none

module trace_select (
  input  logic                                           clk_i,
  input  logic                                           ndmreset_n,
  input  soc_glue_pkg::core_trace_t [`SOC_NUM_HARTS-1:0] core_trace_i,
  input  logic                                           core_sel_i,
  output soc_glue_pkg::snoop_trace_t                     trace_o
);

  import soc_glue_pkg::*;

  core_trace_t  sel_trace;
  snoop_trace_t trace_d;

  // --------------------------------------------------
  // Core select and snooper formatting
  // --------------------------------------------------

  assign sel_trace = core_trace_i[core_sel_i];

  // PC bit 0 is always zero, so the low word drops it and pads below
  always_comb begin : p_format
    trace_d.priv_lvl = sel_trace.priv;
    trace_d.pc_src_h = {1'b0, sel_trace.pc_src[62:32]};
    trace_d.pc_src_l = {sel_trace.pc_src[31:1], 1'b0};
    trace_d.pc_dst_h = {1'b0, sel_trace.pc_dst[62:32]};
    trace_d.pc_dst_l = {sel_trace.pc_dst[31:1], 1'b0};
    trace_d.metadata = {28'b0, sel_trace.metadata};
    trace_d.opcode   = sel_trace.opcode;
    trace_d.pc_v     = sel_trace.pc_src_v;
  end

  // Registered towards the snooper
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_trace
    if (!ndmreset_n) begin
      trace_o <= '0;
    end else begin
      trace_o <= trace_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/debug_req_holdoff.sv
`include "soc_glue_params.svh"

`default_nettype none

module debug_req_holdoff #(
  parameter int unsigned DelCycles = `SOC_DMI_DEL_CYCLES
) (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic [`SOC_NUM_HARTS-1:0] dbg_req_i,
  output logic [`SOC_NUM_HARTS-1:0] dbg_req_o,
  output logic                      dbg_holdoff_o
);

  // Wide enough to hold the full load value
  localparam int unsigned CntWidth = $clog2(DelCycles + 1);

  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] cnt_q;

  // --------------------------------------------------
  // Boot hold-off counter
  // --------------------------------------------------

  assign dbg_holdoff_o = (cnt_q != '0);

  // Saturates at zero
  assign cnt_d = dbg_holdoff_o ? cnt_q - 1'b1 : cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_holdoff_cnt
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(DelCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Boot code runs before any hart can be halted
  assign dbg_req_o = dbg_holdoff_o ? '0 : dbg_req_i;

endmodule

`default_nettype wire

// File: hw/addr_decoder.sv
`include "soc_glue_params.svh"

`default_nettype none

module addr_decoder (
  input  logic                       clk_i,
  input  logic                       ndmreset_n,
  input  logic                       dec_req_i,
  input  logic [`SOC_ADDR_WIDTH-1:0] dec_addr_i,
  output logic                       dec_valid_o,
  output logic                       dec_hit_o,
  output soc_glue_pkg::periph_idx_e  dec_idx_o
);

  import soc_glue_pkg::*;

  // One registered lookup result
  typedef struct packed {
    logic        valid;
    logic        hit;
    periph_idx_e idx;
  } dec_result_t;

  logic [`SOC_NUM_RULES-1:0] rule_match;
  logic                      hit_d;
  periph_idx_e               idx_d;
  dec_result_t               result_q;

  // --------------------------------------------------
  // Range compare against every rule
  // --------------------------------------------------

  always_comb begin : p_rule_match
    for (int unsigned i = 0; i < `SOC_NUM_RULES; i++) begin
      rule_match[i] = (dec_addr_i >= ADDR_MAP[i].start_addr) &&
                      (dec_addr_i <  ADDR_MAP[i].end_addr);
    end
  end

  // Scan from the top so the lowest matching rule wins
  always_comb begin : p_priority
    hit_d = 1'b0;
    idx_d = DEBUG;
    for (int i = `SOC_NUM_RULES - 1; i >= 0; i--) begin
      if (rule_match[i]) begin
        hit_d = 1'b1;
        idx_d = ADDR_MAP[i].idx;
      end
    end
  end

  // --------------------------------------------------
  // Output stage
  // --------------------------------------------------

  // Result is captured only on a request strobe
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_result
    if (!ndmreset_n) begin
      result_q <= '0;
    end else begin
      result_q.valid <= dec_req_i;
      if (dec_req_i) begin
        result_q.hit <= hit_d;
        result_q.idx <= idx_d;
      end
    end
  end

  assign dec_valid_o = result_q.valid;
  assign dec_hit_o   = result_q.hit;
  assign dec_idx_o   = result_q.idx;

endmodule

`default_nettype wire

// File: hw/soc_glue_pkg.sv
`include "soc_glue_params.svh"

`default_nettype none

package soc_glue_pkg;

  // --------------------------------------------------
  // Crossbar address map
  // --------------------------------------------------

  // Crossbar master port index
  typedef enum logic [2:0] {
    DEBUG = 3'd0,
    ROM   = 3'd1,
    CLINT = 3'd2,
    PLIC  = 3'd3,
    APB   = 3'd4,
    L2SPM = 3'd5,
    HYPER = 3'd6
  } periph_idx_e;

  // Covers start_addr up to but excluding end_addr
  typedef struct packed {
    periph_idx_e                idx;
    logic [`SOC_ADDR_WIDTH-1:0] start_addr;
    logic [`SOC_ADDR_WIDTH-1:0] end_addr;
  } addr_rule_t;

  localparam logic [`SOC_ADDR_WIDTH-1:0] DebugBase    = 64'h0000_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] DebugLength  = 64'h0000_1000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] RomBase      = 64'h0001_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] RomLength    = 64'h0001_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] ClintBase    = 64'h0200_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] ClintLength  = 64'h000C_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] PlicBase     = 64'h0C00_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] PlicLength   = 64'h0400_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] ApbBase      = 64'h1A10_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] ApbLength    = 64'h0010_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] L2SpmBase    = 64'h1C00_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] L2SpmLength  = 64'h0008_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] HyperBase    = 64'h8000_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] HyperLength  = 64'h4000_0000;
  // Last-level scratchpad, served by the hyperbus port
  localparam logic [`SOC_ADDR_WIDTH-1:0] LlcSpmBase   = 64'h7000_0000;
  localparam logic [`SOC_ADDR_WIDTH-1:0] LlcSpmLength = 64'h0002_0000;

  // Entry 0 has the highest priority
  localparam addr_rule_t ADDR_MAP [`SOC_NUM_RULES] = '{
    '{idx: DEBUG, start_addr: DebugBase,  end_addr: DebugBase  + DebugLength },
    '{idx: ROM,   start_addr: RomBase,    end_addr: RomBase    + RomLength   },
    '{idx: CLINT, start_addr: ClintBase,  end_addr: ClintBase  + ClintLength },
    '{idx: PLIC,  start_addr: PlicBase,   end_addr: PlicBase   + PlicLength  },
    '{idx: APB,   start_addr: ApbBase,    end_addr: ApbBase    + ApbLength   },
    '{idx: L2SPM, start_addr: L2SpmBase,  end_addr: L2SpmBase  + L2SpmLength },
    '{idx: HYPER, start_addr: HyperBase,  end_addr: HyperBase  + HyperLength },
    '{idx: HYPER, start_addr: LlcSpmBase, end_addr: LlcSpmBase + LlcSpmLength}
  };

  // --------------------------------------------------
  // Control-flow trace records
  // --------------------------------------------------

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Raw record as emitted by one core
  typedef struct packed {
    logic                     pc_src_v;
    logic [`SOC_PC_WIDTH-1:0] pc_src;
    logic [`SOC_PC_WIDTH-1:0] pc_dst;
    logic [3:0]               metadata;
    priv_lvl_e                priv;
    logic [31:0]              opcode;
  } core_trace_t;

  // Snooper record, PCs split into 32-bit words
  typedef struct packed {
    priv_lvl_e   priv_lvl;
    logic [31:0] pc_src_h;
    logic [31:0] pc_src_l;
    logic [31:0] pc_dst_h;
    logic [31:0] pc_dst_l;
    logic [31:0] metadata;
    logic [31:0] opcode;
    logic        pc_v;
  } snoop_trace_t;

endpackage

`default_nettype wire

// File: hw/soc_glue_params.svh
`ifndef SOC_GLUE_PARAMS_SVH
`define SOC_GLUE_PARAMS_SVH

`default_nettype none

// Number of application cores
`define SOC_NUM_HARTS 2

// Crossbar request address and core PC widths
`define SOC_ADDR_WIDTH 64
`define SOC_PC_WIDTH 63

// Entries in the crossbar address map
`define SOC_NUM_RULES 8

// Boot window before debug requests reach the harts
`define SOC_DMI_DEL_CYCLES 500

`default_nettype wire

`endif
